// ==== Makefile ====
VERILATOR ?= verilator
TOP ?= tb_minimig_glue
FILELIST ?= sim.f
OBJ_DIR ?= obj_dir
LOG ?= sim.log
VFLAGS ?= --binary --timing --assert
FAIL_MSG ?= Test FAILED
PASS_MSG ?= Test OK

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build with $(VERILATOR), run $(TOP), check $(LOG)"
	@echo "  clean  remove $(OBJ_DIR) and $(LOG)"
	@echo "  help   this list"
	@echo "variables: VERILATOR TOP FILELIST OBJ_DIR LOG VFLAGS"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)
	./$(OBJ_DIR)/V$(TOP) > $(LOG) 2>&1 || true
	@cat $(LOG)
	@if grep -q "$(FAIL_MSG)" $(LOG); then echo "simulation reported errors"; exit 1; fi
	@if ! grep -q "$(PASS_MSG)" $(LOG); then echo "simulation ended early"; exit 1; fi

clean:
	rm -rf $(OBJ_DIR) $(LOG)

// ==== boot_control.sv ====
`timescale 1ns/1ns

module boot_control (
	input logic clk,
	input logic rst,
	input logic clk7_en, // 7 MHz enable
	input logic cpu_reset_in_n, // reset instruction from the cpu core
	input logic user_reset, // reset from the osd
	input logic cpu_halt_req, // host wants the cpu held
	input logic ciaa_write,
	input glue_pkg::video_std_e ntsc_req, // standard chosen in the menu
	output logic sys_reset,
	output logic cpu_reset_n,
	output logic ovl, // kickstart overlay at address 0
	output glue_pkg::video_std_e ntsc
);

	logic cpu_run_q; // first stage of the cpu reset release

	// --------------------
	// reset combination
	// --------------------
	assign sys_reset = rst | user_reset | ~cpu_reset_in_n;

	// two flops from cause to cpu reset pin, both edges
	// rst reaches them through sys_reset
	always_ff @(posedge clk) begin
		cpu_run_q <= ~(sys_reset | cpu_halt_req);
		cpu_reset_n <= cpu_run_q;
	end

	// --------------------
	// kickstart overlay
	// --------------------
	// rom mirrored at 0 until the first cia-a write
	always_ff @(posedge clk) begin
		if (rst || !cpu_reset_n || !cpu_reset_in_n) begin
			ovl <= 1'b1; // set wins over the clear below
		end else if (ciaa_write) begin
			ovl <= 1'b0; // kickstart has turned it off
		end
	end

	// --------------------
	// pal/ntsc latch
	// --------------------
	// agnus only switches standard while in reset
	always_ff @(posedge clk) begin
		if (rst) begin
			ntsc <= glue_pkg::STD_PAL;
		end else if (sys_reset && clk7_en) begin
			ntsc <= ntsc_req;
		end
	end

endmodule

// ==== cpu_bus_glue.sv ====
`timescale 1ns/1ns
`include "glue_settings.svh"

module cpu_bus_glue (
	input glue_pkg::cpu_req_t cpu_req,
	input logic [3:0] rtc_nibble, // selected clock nibble
	input logic int7, // level 7 request, freeze button
	input logic [`GLUE_IPL_W-1:0] ipl_paula, // active low
	output logic ciaa_write,
	output logic [`GLUE_DATA_W-1:0] cpu_rdata,
	output logic [`GLUE_IPL_W-1:0] cpu_ipl // active low
);

	glue_pkg::region_e region;
	logic [7:0] upper_byte; // address bits 23..16
	logic wr; // either byte lane written
	logic [`GLUE_DATA_W-1:0] rtc_rdata; // clock contribution to the read bus

	assign upper_byte = cpu_req.address[`GLUE_ADDR_W:16];
	assign wr = cpu_req.hwr | cpu_req.lwr;

	// --------------------
	// address decode
	// --------------------
	always_comb begin
		region = glue_pkg::REGION_NONE;
		if (upper_byte == `GLUE_RTC_REGION) begin
			region = glue_pkg::REGION_RTC;
		end else if (upper_byte == `GLUE_CIA_REGION && !cpu_req.address[`GLUE_CIAA_BIT]) begin
			region = glue_pkg::REGION_CIAA; // cia-b sits where bit 12 is high
		end
	end

	// any write into cia-a, clears overlay downstream
	assign ciaa_write = (region == glue_pkg::REGION_CIAA) && wr;

	// --------------------
	// read data
	// --------------------
	// nibble in bits 3..0, upper bits zero
	always_comb begin
		rtc_rdata = '0;
		if (region == glue_pkg::REGION_RTC && cpu_req.rd) begin
			rtc_rdata[3:0] = rtc_nibble;
		end
	end

	// or-merge of all read sources, only the clock left
	assign cpu_rdata = rtc_rdata;

	// --------------------
	// interrupts
	// --------------------
	assign cpu_ipl = int7 ? '0 : ipl_paula; // all lines low = level 7

endmodule

// ==== glue_pkg.sv ====
`include "glue_settings.svh"

package glue_pkg;

	// one cpu bus cycle, held for the whole cycle
	typedef struct packed {
		logic [`GLUE_ADDR_W:1] address; // word address, a0 not present
		logic rd; // read level
		logic hwr; // upper byte write
		logic lwr; // lower byte write
	} cpu_req_t;

	// clock image from the host
	// toggle flips once per new image
	typedef struct packed {
		logic toggle;
		logic [`GLUE_RTC_W-1:0] time_bcd; // low byte is seconds
	} rtc_host_t;

	// decoded address window
	typedef enum logic [1:0] {
		REGION_NONE = 2'd0,
		REGION_RTC = 2'd1,
		REGION_CIAA = 2'd2
	} region_e;

	// agnus video standard
	typedef enum logic [0:0] {
		STD_PAL = 1'b0,
		STD_NTSC = 1'b1
	} video_std_e;

endpackage

// ==== glue_settings.svh ====
`ifndef GLUE_SETTINGS_SVH
`define GLUE_SETTINGS_SVH

// --------------------
// bus widths
// --------------------
`define GLUE_ADDR_W 23 // cpu word address, bits 23..1
`define GLUE_DATA_W 16 // cpu data bus
`define GLUE_IPL_W 3 // interrupt level lines, active low
`define GLUE_RTC_W 64 // clock image, sixteen bcd nibbles

// --------------------
// address windows
// --------------------
`define GLUE_RTC_REGION 8'hDC // upper address byte of the clock window
`define GLUE_CIA_REGION 8'hBF // upper address byte of the cia window
`define GLUE_CIAA_BIT 12 // low here selects cia-a

// --------------------
// seconds divider
// --------------------
`define GLUE_TICKS_PER_SEC 28375160 // clk edges per second on hardware

`endif

// ==== minimig_glue.sv ====
`timescale 1ns/1ns
`include "glue_settings.svh"

module minimig_glue #(
	parameter int unsigned ticks_per_sec = `GLUE_TICKS_PER_SEC // edges per rtc second
) (
	input logic clk,
	input logic rst,
	input logic clk7_en,
	input glue_pkg::cpu_req_t cpu_req,
	input logic cpu_reset_in_n,
	input logic user_reset,
	input logic cpu_halt_req,
	input glue_pkg::video_std_e ntsc_req,
	input logic int7,
	input logic [`GLUE_IPL_W-1:0] ipl_paula, // active low
	input glue_pkg::rtc_host_t rtc_host,
	output logic [`GLUE_DATA_W-1:0] cpu_rdata,
	output logic [`GLUE_IPL_W-1:0] cpu_ipl,
	output logic cpu_reset_n,
	output logic sys_reset,
	output logic ovl,
	output glue_pkg::video_std_e ntsc
);

	logic [3:0] rtc_nibble; // clock nibble to the read mux
	logic ciaa_write; // clears overlay

	// decode, read merge, level 7
	cpu_bus_glue i_cpu_bus_glue (
		.cpu_req(cpu_req),
		.rtc_nibble(rtc_nibble),
		.int7(int7),
		.ipl_paula(ipl_paula),
		.ciaa_write(ciaa_write),
		.cpu_rdata(cpu_rdata),
		.cpu_ipl(cpu_ipl)
	);

	// battery clock, indexed by address bits 5..2
	rtc_clock #(.ticks_per_sec(ticks_per_sec)) i_rtc_clock (
		.clk(clk),
		.rst(rst),
		.rtc_host(rtc_host),
		.nibble_index(cpu_req.address[5:2]),
		.rtc_nibble(rtc_nibble)
	);

	// resets, overlay, video standard
	boot_control i_boot_control (
		.clk(clk),
		.rst(rst),
		.clk7_en(clk7_en),
		.cpu_reset_in_n(cpu_reset_in_n),
		.user_reset(user_reset),
		.cpu_halt_req(cpu_halt_req),
		.ciaa_write(ciaa_write),
		.ntsc_req(ntsc_req),
		.sys_reset(sys_reset),
		.cpu_reset_n(cpu_reset_n),
		.ovl(ovl),
		.ntsc(ntsc)
	);

endmodule

// ==== minimig_glue_sva.sv ====
`timescale 1ns/1ns
`include "glue_settings.svh"

module minimig_glue_sva (
	input logic clk,
	input glue_pkg::cpu_req_t cpu_req,
	input logic int7,
	input logic [`GLUE_DATA_W-1:0] cpu_rdata,
	input logic [`GLUE_IPL_W-1:0] cpu_ipl,
	input logic sys_reset,
	input logic cpu_reset_n,
	input glue_pkg::video_std_e ntsc
);

	// no read level, nothing on the bus
	rdata_idle: assert property (@(posedge clk) !cpu_req.rd |-> cpu_rdata == '0)
		else $error("cpu_rdata not zero while rd is low");

	ipl_level7: assert property (@(posedge clk) int7 |-> cpu_ipl == '0) // all lines active
		else $error("cpu_ipl not level 7 while int7 is high");

	// standard only moves under reset
	ntsc_in_reset: assert property (@(posedge clk) $changed(ntsc) |-> $past(sys_reset))
		else $error("ntsc changed while sys_reset was low");

	cpu_reset_follows: assert property (@(posedge clk) sys_reset |-> ##2 !cpu_reset_n)
		else $error("cpu_reset_n still high two cycles after sys_reset");

endmodule

bind minimig_glue minimig_glue_sva i_sva (
	.clk(clk),
	.cpu_req(cpu_req),
	.int7(int7),
	.cpu_rdata(cpu_rdata),
	.cpu_ipl(cpu_ipl),
	.sys_reset(sys_reset),
	.cpu_reset_n(cpu_reset_n),
	.ntsc(ntsc)
);

// ==== rtc_clock.sv ====
`timescale 1ns/1ns
`include "glue_settings.svh"

module rtc_clock #(
	parameter int unsigned ticks_per_sec = `GLUE_TICKS_PER_SEC
) (
	input logic clk,
	input logic rst,
	input glue_pkg::rtc_host_t rtc_host,
	input logic [3:0] nibble_index, // address bits 5..2
	output logic [3:0] rtc_nibble
);

	localparam int CNT_W = $clog2(ticks_per_sec + 1);
	localparam logic [CNT_W-1:0] CNT_LAST = CNT_W'(ticks_per_sec - 1); // last tick of a second

	logic [`GLUE_RTC_W-1:0] rtc_reg; // current clock image
	logic [CNT_W-1:0] tick_cnt; // edges within the current second
	logic toggle_q; // host toggle seen last edge
	logic load; // host has a fresh image
	logic [3:0] sec_units;
	logic [3:0] sec_tens;
	logic sec_wrap; // one second elapsed

	assign load = rtc_host.toggle ^ toggle_q;
	assign sec_units = rtc_reg[3:0];
	assign sec_tens = rtc_reg[7:4];
	assign sec_wrap = (tick_cnt == CNT_LAST);

	// --------------------
	// host load and divider
	// --------------------
	always_ff @(posedge clk) begin
		if (rst) begin
			rtc_reg <= '0;
			tick_cnt <= '0;
			toggle_q <= 1'b0;
		end else begin
			toggle_q <= rtc_host.toggle;
			if (load) begin
				// seconds restart from zero on every load
				rtc_reg <= {rtc_host.time_bcd[`GLUE_RTC_W-1:8], 8'h00};
				tick_cnt <= '0;
			end else if (!sec_wrap) begin
				tick_cnt <= tick_cnt + 1'b1;
			end else begin
				tick_cnt <= '0;
				// bcd seconds, stuck at 59
				if (sec_units < 4'd9) begin
					rtc_reg[3:0] <= sec_units + 4'd1;
				end else if (sec_tens < 4'd5) begin
					rtc_reg[7:0] <= {sec_tens + 4'd1, 4'd0}; // carry into tens
				end
			end
		end
	end

	// minutes and up never advance here, the host refreshes them

	// --------------------
	// nibble read
	// --------------------
	// nibble 0 is seconds units, nibble 15 the top of the image
	assign rtc_nibble = rtc_reg[{nibble_index, 2'b00} +: 4];

endmodule

// ==== sim.f ====
+incdir+.
glue_pkg.sv
cpu_bus_glue.sv
rtc_clock.sv
boot_control.sv
minimig_glue.sv
minimig_glue_sva.sv
tb_minimig_glue.sv

// ==== tb_minimig_glue.sv ====
`timescale 1ns/1ns
`include "glue_settings.svh"

module tb_minimig_glue;

	localparam int TICKS = 10; // short rtc second
	localparam int PERIOD = 4;
	localparam int TRIALS = 5; // random delays in the counting test
	localparam int MAX_DELAY = 70 * TICKS; // up to 70 rtc periods
	localparam int LIMIT_NS = (TRIALS * (MAX_DELAY + 4) + 400) * PERIOD; // all tests plus margin

	typedef enum int {K_RDATA, K_IPL, K_CPU_RST, K_SYS_RST, K_OVL, K_NTSC} kind_e;

	logic clk;
	logic rst;
	logic clk7_en;
	glue_pkg::cpu_req_t cpu_req;
	logic cpu_reset_in_n;
	logic user_reset;
	logic cpu_halt_req;
	glue_pkg::video_std_e ntsc_req;
	logic int7;
	logic [`GLUE_IPL_W-1:0] ipl_paula;
	glue_pkg::rtc_host_t rtc_host;
	logic [`GLUE_DATA_W-1:0] cpu_rdata;
	logic [`GLUE_IPL_W-1:0] cpu_ipl;
	logic cpu_reset_n;
	logic sys_reset;
	logic ovl;
	glue_pkg::video_std_e ntsc;

	int edge_count = 0; // rising edges so far
	int load_edge; // edge that took the last image
	logic [`GLUE_RTC_W-1:0] loaded_img;
	int checks = 0;
	int mismatches = 0;
	int tests_run = 0;
	int tests_bad = 0;
	int errs_before; // mismatches when the current test began
	string current_test;
	string name_q[$]; // pending checks filled by the stimulus
	kind_e kind_q[$];
	logic [15:0] exp_q[$];

	minimig_glue #(.ticks_per_sec(TICKS)) i_dut (.*);

	initial begin
		clk = 1'b0;
		forever #(PERIOD / 2) clk = ~clk;
	end

	always @(posedge clk) edge_count <= edge_count + 1;

	// --------------------
	// reference model
	// --------------------
	function automatic logic [3:0] expected_nibble(input logic [63:0] img, input int elapsed,
			input logic [3:0] idx);
		logic [63:0] cur;
		int secs;
		secs = elapsed / TICKS; // whole periods since load
		if (secs > 59) secs = 59; // seconds stop at 59
		cur = img;
		cur[7:0] = {4'(secs / 10), 4'(secs % 10)}; // bcd tens and units
		return cur[int'(idx) * 4 +: 4];
	endfunction

	function automatic glue_pkg::region_e expected_region(input logic [23:1] a);
		if (a[23:16] == `GLUE_RTC_REGION) return glue_pkg::REGION_RTC;
		if (a[23:16] == `GLUE_CIA_REGION && !a[`GLUE_CIAA_BIT]) begin
			return glue_pkg::REGION_CIAA;
		end
		return glue_pkg::REGION_NONE;
	endfunction

	function automatic logic [2:0] expected_ipl(input logic i7, input logic [2:0] ipl);
		return i7 ? 3'b000 : ipl; // level 7 = all lines low
	endfunction

	function automatic logic [15:0] expected_rdata(input logic [23:1] a, input logic rd);
		if (expected_region(a) != glue_pkg::REGION_RTC || !rd) return 16'd0;
		return {12'd0, expected_nibble(loaded_img, edge_count - load_edge, a[5:2])};
	endfunction

	function automatic logic [23:1] outside_addr();
		logic [23:1] a;
		a = 23'($urandom);
		// keep away from both windows and cia-b
		while (expected_region(a) != glue_pkg::REGION_NONE
				|| a[23:16] == `GLUE_CIA_REGION) begin
			a = 23'($urandom);
		end
		return a;
	endfunction

	function automatic logic [23:1] rtc_addr(input logic [3:0] idx);
		logic [23:1] a;
		a = '0;
		a[23:16] = `GLUE_RTC_REGION;
		a[5:2] = idx; // nibble select
		return a;
	endfunction

	function automatic logic [15:0] sample_output(input kind_e kind);
		case (kind)
			K_RDATA: return cpu_rdata;
			K_IPL: return {13'd0, cpu_ipl};
			K_CPU_RST: return {15'd0, cpu_reset_n};
			K_SYS_RST: return {15'd0, sys_reset};
			K_OVL: return {15'd0, ovl};
			default: return 16'(ntsc);
		endcase
	endfunction

	// --------------------
	// checking
	// --------------------
	task automatic compare_value(input string name, input logic [15:0] exp,
			input logic [15:0] act);
		checks++;
		if (act !== exp) begin
			mismatches++;
			$display("FAILED %s/%s: expected %0h, actual %0h", current_test, name, exp, act);
		end
	endtask

	// queued at a falling edge and compared 1 ns later
	task automatic expect_out(input string name, input kind_e kind, input logic [15:0] exp);
		name_q.push_back(name);
		kind_q.push_back(kind);
		exp_q.push_back(exp);
	endtask

	initial begin
		forever begin
			@(negedge clk);
			#1;
			while (kind_q.size() > 0) begin
				compare_value(name_q.pop_front(), exp_q.pop_front(),
					sample_output(kind_q.pop_front()));
			end
		end
	end

	task automatic start_test(input string name);
		current_test = name;
		errs_before = mismatches;
		@(negedge clk);
	endtask

	task automatic finish_test();
		#2; // compare process has drained the queue
		tests_run++;
		if (mismatches != errs_before) tests_bad++;
		$display("%s: %0d mismatches", current_test, mismatches - errs_before);
	endtask

	task automatic drive_bus(input logic [23:1] a, input logic rd, input logic hwr,
			input logic lwr);
		cpu_req.address = a;
		cpu_req.rd = rd;
		cpu_req.hwr = hwr;
		cpu_req.lwr = lwr;
	endtask

	task automatic load_image(input logic [63:0] img);
		rtc_host.time_bcd = img;
		rtc_host.toggle = ~rtc_host.toggle; // host marks a new image
		loaded_img = img;
		load_edge = edge_count + 1; // taken on the next rising edge
	endtask

	task automatic read_nibble(input logic [3:0] idx);
		drive_bus(rtc_addr(idx), 1'b1, 1'b0, 1'b0);
		expect_out($sformatf("nibble_%0d", idx), K_RDATA,
			expected_rdata(rtc_addr(idx), 1'b1));
	endtask

	// --------------------
	// tests
	// --------------------
	task automatic reset_release_test();
		start_test("reset_release");
		@(negedge clk); // rst has seen 2 rising edges
		expect_out("cpu_low_in_reset", K_CPU_RST, 16'd0);
		expect_out("ovl_in_reset", K_OVL, 16'd1);
		expect_out("pal_in_reset", K_NTSC, 16'(glue_pkg::STD_PAL));
		rst = 1'b0;
		@(negedge clk);
		expect_out("release_edge1", K_CPU_RST, 16'd0);
		@(negedge clk);
		expect_out("release_edge2", K_CPU_RST, 16'd1);
		cpu_halt_req = 1'b1;
		expect_out("halt_no_sys_reset", K_SYS_RST, 16'd0);
		@(negedge clk);
		expect_out("halt_edge1", K_CPU_RST, 16'd1);
		@(negedge clk);
		expect_out("halt_edge2", K_CPU_RST, 16'd0);
		cpu_halt_req = 1'b0;
		repeat (2) @(negedge clk);
		expect_out("halt_released", K_CPU_RST, 16'd1);
		finish_test();
	endtask

	task automatic overlay_test();
		logic [23:1] cia_a;
		start_test("overlay");
		cia_a = '0;
		cia_a[23:16] = `GLUE_CIA_REGION; // bit 12 low
		drive_bus(cia_a, 1'b1, 1'b0, 1'b0);
		@(negedge clk);
		expect_out("ovl_after_cia_read", K_OVL, 16'd1);
		drive_bus(outside_addr(), 1'b0, 1'b1, 1'b1);
		@(negedge clk);
		expect_out("ovl_after_other_write", K_OVL, 16'd1);
		drive_bus(cia_a, 1'b0, 1'b0, 1'b1);
		@(negedge clk);
		expect_out("ovl_cleared", K_OVL, 16'd0);
		drive_bus('0, 1'b0, 1'b0, 1'b0);
		cpu_reset_in_n = 1'b0; // reset instruction
		expect_out("sys_reset_from_cpu", K_SYS_RST, 16'd1);
		@(negedge clk);
		expect_out("ovl_set_again", K_OVL, 16'd1);
		cpu_reset_in_n = 1'b1;
		repeat (3) @(negedge clk); // cpu reset lets go
		finish_test();
	endtask

	task automatic clock_load_test();
		start_test("clock_load");
		load_image({$urandom, $urandom});
		for (int i = 0; i < 16; i++) begin
			@(negedge clk);
			read_nibble(4'(i));
		end
		finish_test();
	endtask

	task automatic clock_count_test();
		int delay;
		start_test("clock_count");
		for (int t = 0; t < TRIALS; t++) begin
			load_image({$urandom, $urandom});
			delay = int'($urandom % (MAX_DELAY + 1));
			repeat (delay + 1) @(negedge clk);
			read_nibble(4'd0); // seconds units
			@(negedge clk);
			read_nibble(4'd1); // seconds tens
			@(negedge clk);
		end
		finish_test();
	endtask

	task automatic gating_irq_test();
		logic [23:1] a;
		logic rd;
		start_test("gating_irq");
		for (int i = 0; i < 12; i++) begin
			a = (i % 3 == 0) ? rtc_addr(4'($urandom)) : outside_addr();
			rd = 1'(i / 3); // clock window sees rd low and high in turn
			drive_bus(a, rd, ~rd, 1'b0); // clock window hit without rd is a write
			expect_out("read_gating", K_RDATA, expected_rdata(a, rd));
			@(negedge clk);
		end
		drive_bus('0, 1'b0, 1'b0, 1'b0);
		for (int v = 0; v < 16; v++) begin
			int7 = v[3];
			ipl_paula = 3'(v);
			expect_out("ipl", K_IPL, {13'd0, expected_ipl(int7, ipl_paula)});
			@(negedge clk);
		end
		int7 = 1'b0;
		ipl_paula = 3'b111;
		finish_test();
	endtask

	task automatic video_std_test();
		start_test("video_std");
		ntsc_req = glue_pkg::STD_NTSC;
		for (int i = 0; i < 4; i++) begin
			clk7_en = ~clk7_en;
			@(negedge clk);
		end
		expect_out("ntsc_outside_reset", K_NTSC, 16'(glue_pkg::STD_PAL));
		clk7_en = 1'b0;
		user_reset = 1'b1;
		expect_out("sys_reset_from_user", K_SYS_RST, 16'd1);
		repeat (2) @(negedge clk);
		expect_out("ntsc_waits_clk7", K_NTSC, 16'(glue_pkg::STD_PAL));
		clk7_en = 1'b1;
		@(negedge clk);
		expect_out("ntsc_taken", K_NTSC, 16'(glue_pkg::STD_NTSC));
		user_reset = 1'b0;
		ntsc_req = glue_pkg::STD_PAL; // ignored from here on
		repeat (4) @(negedge clk);
		expect_out("ntsc_kept", K_NTSC, 16'(glue_pkg::STD_NTSC));
		finish_test();
	endtask

	initial begin
		void'($urandom(32'ha82d));
		rst = 1'b1;
		clk7_en = 1'b0;
		cpu_req = '0;
		cpu_reset_in_n = 1'b1;
		user_reset = 1'b0;
		cpu_halt_req = 1'b0;
		ntsc_req = glue_pkg::STD_PAL;
		int7 = 1'b0;
		ipl_paula = 3'b111; // no interrupt
		rtc_host = '0;
		reset_release_test();
		overlay_test();
		clock_load_test();
		clock_count_test();
		gating_irq_test();
		video_std_test();
		$display("tests %0d, with errors %0d, checks %0d, mismatches %0d",
			tests_run, tests_bad, checks, mismatches);
		if (mismatches == 0) begin
			$display("Test OK");
		end else begin
			$display("Test FAILED");
		end
		$finish;
	end

	// hang guard
	initial begin
		#(LIMIT_NS);
		$display("watchdog: tests did not complete within %0d ns, run stopped", LIMIT_NS);
		$display("Test FAILED");
		$finish;
	end

endmodule
